//--- verilog.f
source/throttle_pkg.sv
source/pwm_pkg.sv
source/limiter_if.sv
source/limiter_ctrl.sv
source/throttle_history.sv
source/throttle_curve.sv
source/motor_pwm.sv
source/throttle_path_top.sv
bench/tb_clock.sv
bench/tb_throttle_path.sv

//--- Bender.yml
package:
  name: throttle_path

sources:
  - files:
      - source/throttle_pkg.sv
      - source/pwm_pkg.sv
      - source/limiter_if.sv
      - source/limiter_ctrl.sv
      - source/throttle_history.sv
      - source/throttle_curve.sv
      - source/motor_pwm.sv
      - source/throttle_path_top.sv
  - target: test
    files:
      - bench/tb_clock.sv
      - bench/tb_throttle_path.sv

//--- bench/tb_throttle_path.sv
// testbench for the throttle conditioning path
// LFSR stimulus, reference model of strobes, history, curve and motor pulse
// concurrent checks, timeout and report

`timescale 1ns/1ps
`default_nettype none

module tb_throttle_path;

	logic       us_clk;
	logic       resetn;
	logic [7:0] throttle_pwm_value_in;
	logic       start_signal;
	logic [7:0] throttle_pwm_value_out;
	logic       active_signal;
	logic       complete_signal;
	logic       motor_pwm_out;

	int          errors;
	int          tests;
	int          cycles;
	logic [31:0] lfsr_state;

	// reference model state
	int         phase;
	logic [7:0] model_sample;
	logic [7:0] model_hist [8];
	logic [7:0] exp_result;
	logic [7:0] exp_out;
	logic       exp_active;
	logic       exp_complete;
	int         model_tick;
	int         model_width;
	logic       exp_pwm;

	tb_clock i_tb_clock (
		.us_clk (us_clk),
		.resetn (resetn)
	);

	throttle_path_top i_throttle_path_top (
		.us_clk                 (us_clk),
		.resetn                 (resetn),
		.throttle_pwm_value_in  (throttle_pwm_value_in),
		.start_signal           (start_signal),
		.throttle_pwm_value_out (throttle_pwm_value_out),
		.active_signal          (active_signal),
		.complete_signal        (complete_signal),
		.motor_pwm_out          (motor_pwm_out)
	);

	// taps 32 22 2 1, one step per bit taken
	function automatic logic [7:0] next_random_byte();
		logic [7:0] value;
		logic       fb;
		value = '0;
		for (int i = 0; i < 8; i++) begin
			fb = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
			lfsr_state = {lfsr_state[30:0], fb};
			value = {value[6:0], fb};
		end
		return value;
	endfunction

	// three-segment curve on the average, saturated at 255
	function automatic logic [7:0] curve_of_sum(int sum);
		int avg;
		int v;
		avg = sum / 8;
		if (avg < 42)
			v = 2 * avg;
		else if (avg > 209)
			v = 2 * avg - 252;
		else
			v = avg / 2 + 61;
		if (v > 255)
			v = 255;
		return v[7:0];
	endfunction

	// strobe and datapath model, phase 1 is the cycle after the sampling edge
	always @(posedge us_clk or negedge resetn) begin
		int sum;
		if (!resetn) begin
			phase = 0;
			model_sample = '0;
			for (int i = 0; i < 8; i++)
				model_hist[i] = '0;
			exp_result   <= '0;
			exp_out      <= '0;
			exp_active   <= 1'b0;
			exp_complete <= 1'b0;
		end else begin
			exp_active   <= (phase >= 1) && (phase <= 5);
			exp_complete <= (phase == 6);
			if (phase == 1) begin
				sum = 0;
				if (model_sample < 10) begin
					for (int i = 0; i < 8; i++)
						model_hist[i] = '0;
				end else begin
					for (int i = 7; i > 0; i--)
						model_hist[i] = model_hist[i-1];
					model_hist[0] = model_sample;
				end
				for (int i = 0; i < 8; i++)
					sum += model_hist[i];
				exp_result <= curve_of_sum(sum);
			end
			if (phase == 5)
				exp_out <= exp_result;
			if (phase == 0) begin
				if (start_signal)
					model_sample = throttle_pwm_value_in;
				phase = start_signal ? 1 : 0;
			end else begin
				phase = (phase == 6) ? 0 : phase + 1;
			end
		end
	end

	// motor pulse model, frame of 1024 ticks from the first edge after reset
	always @(posedge us_clk or negedge resetn) begin
		if (!resetn) begin
			model_tick  <= 0;
			model_width = 0;
			exp_pwm     <= 1'b0;
		end else begin
			// width of this frame from the output held at its start
			if (model_tick == 0)
				model_width = 256 + exp_out;
			exp_pwm    <= (model_tick < model_width);
			model_tick <= (model_tick == 1023) ? 0 : model_tick + 1;
		end
	end

	a_reset_state: assert property (@(posedge us_clk)
		!resetn |-> (!active_signal && !complete_signal && !motor_pwm_out
			&& throttle_pwm_value_out == 8'd0))
	else begin
		$display("outputs not idle during reset at %0t", $time);
		errors++;
	end

	a_active: assert property (@(posedge us_clk) disable iff (!resetn)
		active_signal == exp_active)
	else begin
		$display("error t=%0t active_signal expected %0b got %0b",
			$time, $sampled(exp_active), $sampled(active_signal));
		errors++;
	end

	a_complete: assert property (@(posedge us_clk) disable iff (!resetn)
		complete_signal == exp_complete)
	else begin
		$display("error t=%0t complete_signal expected %0b got %0b",
			$time, $sampled(exp_complete), $sampled(complete_signal));
		errors++;
	end

	a_output: assert property (@(posedge us_clk) disable iff (!resetn)
		throttle_pwm_value_out == exp_out)
	else begin
		$display("error t=%0t throttle_pwm_value_out expected %0d got %0d",
			$time, $sampled(exp_out), $sampled(throttle_pwm_value_out));
		errors++;
	end

	a_motor_pwm: assert property (@(posedge us_clk) disable iff (!resetn)
		motor_pwm_out == exp_pwm)
	else begin
		$display("error t=%0t motor_pwm_out expected %0b got %0b",
			$time, $sampled(exp_pwm), $sampled(motor_pwm_out));
		errors++;
	end

	// one sample through the path, optionally poking start while busy
	task automatic send_sample(input logic [7:0] value, input bit poke_busy);
		@(posedge us_clk);
		#2;
		start_signal          = 1'b1;
		throttle_pwm_value_in = value;
		@(posedge us_clk);
		#2;
		start_signal = 1'b0;
		if (poke_busy) begin
			start_signal          = 1'b1;
			throttle_pwm_value_in = next_random_byte();
			@(posedge us_clk);
			#2;
			start_signal = 1'b0;
		end
		do begin
			@(posedge us_clk);
			#1;
		end while (complete_signal !== 1'b1);
	endtask

	task automatic finish_test(input string name, input int errors_before);
		tests++;
		$display("test %0d %s finished with %0d errors", tests, name, errors - errors_before);
	endtask

	always @(posedge us_clk) begin
		cycles++;
		if (cycles >= 8000) begin
			$display("timeout after %0d cycles", cycles);
			$display("TB FAILED");
			$finish;
		end
	end

	initial begin
		int        mark;
		logic [7:0] v;
		errors                = 0;
		tests                 = 0;
		cycles                = 0;
		lfsr_state            = 32'ha674b376;
		start_signal          = 1'b0;
		throttle_pwm_value_in = '0;

		mark = errors;
		@(posedge resetn);
		@(posedge us_clk);
		#1;
		if (active_signal || complete_signal || throttle_pwm_value_out != 8'd0) begin
			$display("outputs not idle after reset release");
			errors++;
		end
		finish_test("reset state", mark);

		mark = errors;
		send_sample(8'd100, 1'b0);
		send_sample(8'd120, 1'b1);
		send_sample(8'd80, 1'b1);
		finish_test("strobe timing", mark);

		mark = errors;
		for (int n = 0; n < 30; n++) begin
			v = next_random_byte();
			if (v < 8'd10)
				v = v + 8'd10;
			send_sample(v, 1'b0);
		end
		// constant histories hit each segment, both breakpoints and saturation
		for (int k = 0; k < 5; k++) begin
			case (k)
				0: v = 8'd41;
				1: v = 8'd42;
				2: v = 8'd209;
				3: v = 8'd210;
				default: v = 8'd255;
			endcase
			repeat (8) send_sample(v, 1'b0);
		end
		finish_test("average and curve", mark);

		mark = errors;
		send_sample(8'd5, 1'b0);
		send_sample(8'd200, 1'b0);
		finish_test("idle clear", mark);

		mark = errors;
		repeat (2) @(posedge us_clk);
		send_sample(8'd30, 1'b0);
		repeat (2 * 1024) @(posedge us_clk);
		send_sample(8'd250, 1'b0);
		repeat (3 * 1024) @(posedge us_clk);
		finish_test("motor pulse", mark);

		$display("tests %0d errors %0d", tests, errors);
		if (errors == 0)
			$display("TB PASSED");
		else
			$display("TB FAILED");
		$finish;
	end

endmodule

`default_nettype wire

//--- bench/tb_clock.sv
// testbench clock and reset generator
// 40 ns us_clk, resetn held low for 10 cycles

`timescale 1ns/1ps
`default_nettype none

module tb_clock (
	output logic us_clk,
	output logic resetn
);

	initial begin
		us_clk = 1'b0;
		forever #20 us_clk = ~us_clk;
	end

	initial begin
		resetn = 1'b0;
		repeat (10) @(posedge us_clk);
		#2 resetn = 1'b1;
	end

endmodule

`default_nettype wire

//--- source/throttle_path_top.sv
// throttle conditioning path top level
// controller, history, curve and motor pulse wired through limiter_if

`timescale 1ns/1ps
`default_nettype none

module throttle_path_top import throttle_pkg::*; (
	input  wire      us_clk,
	input  wire      resetn,
	input  rec_val_t throttle_pwm_value_in,
	input  wire      start_signal,
	output rec_val_t throttle_pwm_value_out,
	output logic     active_signal,
	output logic     complete_signal,
	output logic     motor_pwm_out
);

	rec_val_t curve_value;

	limiter_if lim ();

	limiter_ctrl i_limiter_ctrl (
		.us_clk                 (us_clk),
		.resetn                 (resetn),
		.start_signal           (start_signal),
		.throttle_pwm_value_in  (throttle_pwm_value_in),
		.lim                    (lim.ctrl),
		.curve_value            (curve_value),
		.throttle_pwm_value_out (throttle_pwm_value_out),
		.active_signal          (active_signal),
		.complete_signal        (complete_signal)
	);

	throttle_history i_throttle_history (
		.us_clk (us_clk),
		.resetn (resetn),
		.lim    (lim.hist)
	);

	throttle_curve i_throttle_curve (
		.us_clk      (us_clk),
		.resetn      (resetn),
		.lim         (lim.curve),
		.curve_value (curve_value)
	);

	// pulse follows the held output level
	motor_pwm i_motor_pwm (
		.us_clk         (us_clk),
		.resetn         (resetn),
		.throttle_value (throttle_pwm_value_out),
		.motor_pwm_out  (motor_pwm_out)
	);

endmodule

`default_nettype wire

//--- source/motor_pwm.sv
// motor pulse generator
// fixed frame, high width of base ticks plus throttle value

`timescale 1ns/1ps
`default_nettype none

module motor_pwm import throttle_pkg::*, pwm_pkg::*; (
	input  wire      us_clk,
	input  wire      resetn,
	input  rec_val_t throttle_value,
	output logic     motor_pwm_out
);

	pwm_count_t tick;
	pwm_count_t width_q;

	// frame counter, tick 0 starts a frame
	always_ff @(posedge us_clk or negedge resetn) begin
		if (!resetn)
			tick <= '0;
		else if (tick == pwm_count_t'(PWM_FRAME_TICKS - 1))
			tick <= '0;
		else
			tick <= tick + 1'b1;
	end

	// width captured once per frame so a new result waits for the next one
	always_ff @(posedge us_clk or negedge resetn) begin
		if (!resetn)
			width_q <= '0;
		else if (tick == '0)
			width_q <= PWM_BASE_TICKS + pwm_count_t'(throttle_value);
	end

	// base width is never zero, so tick 0 always drives high
	always_ff @(posedge us_clk or negedge resetn) begin
		if (!resetn)
			motor_pwm_out <= 1'b0;
		else if (tick == '0)
			motor_pwm_out <= 1'b1;
		else
			motor_pwm_out <= (tick < width_q);
	end

endmodule

`default_nettype wire

//--- source/throttle_curve.sv
// averaging shift of the history sum
// three-segment throttle curve with saturation, registered

`timescale 1ns/1ps
`default_nettype none

module throttle_curve import throttle_pkg::*; (
	input  wire      us_clk,
	input  wire      resetn,
	limiter_if.curve lim,
	output rec_val_t curve_value
);

	ops_t     average_q;
	ops_t     curve_raw;
	rec_val_t curve_q;

	always_ff @(posedge us_clk or negedge resetn) begin
		if (!resetn)
			average_q <= '0;
		else if (lim.average_load)
			average_q <= lim.sum >> HIST_SHIFT;
	end

	// steep at both ends, gentle through the middle
	always_comb begin
		if (average_q < CURVE_LOW_END)
			curve_raw = average_q << 1;
		else if (average_q > CURVE_HIGH_END)
			curve_raw = (average_q << 1) - CURVE_HIGH_OFFSET;
		else
			curve_raw = (average_q >> 1) + CURVE_MID_OFFSET;
	end

	// top of the high segment overshoots 255
	always_ff @(posedge us_clk or negedge resetn) begin
		if (!resetn)
			curve_q <= '0;
		else if (lim.scale) begin
			if (curve_raw > REC_VAL_MAX)
				curve_q <= rec_val_t'(REC_VAL_MAX);
			else
				curve_q <= rec_val_t'(curve_raw);
		end
	end

	assign curve_value = curve_q;

	// the history sum divided by its depth fits one sample
	a_average_range: assert property (
		@(posedge us_clk) disable iff (!resetn)
		average_q <= REC_VAL_MAX
	);

endmodule

`default_nettype wire

//--- source/throttle_history.sv
// eight-entry throttle sample history
// shift in on push, zero on clear, registered sum on add

`timescale 1ns/1ps
`default_nettype none

module throttle_history import throttle_pkg::*; (
	input wire      us_clk,
	input wire      resetn,
	limiter_if.hist lim
);

	rec_val_t entries [HIST_DEPTH];
	ops_t     sum_next;
	ops_t     sum_q;

	// entry zero holds the newest sample
	always_ff @(posedge us_clk or negedge resetn) begin
		if (!resetn) begin
			for (int i = 0; i < HIST_DEPTH; i++)
				entries[i] <= '0;
		end else if (lim.clear) begin
			for (int i = 0; i < HIST_DEPTH; i++)
				entries[i] <= '0;
		end else if (lim.push) begin
			entries[0] <= lim.sample;
			for (int i = 1; i < HIST_DEPTH; i++)
				entries[i] <= entries[i-1];
		end
	end

	// 8 x 255 stays well inside ops_t
	always_comb begin
		sum_next = '0;
		for (int i = 0; i < HIST_DEPTH; i++)
			sum_next = sum_next + ops_t'(entries[i]);
	end

	always_ff @(posedge us_clk or negedge resetn) begin
		if (!resetn)
			sum_q <= '0;
		else if (lim.add)
			sum_q <= sum_next;
	end

	assign lim.sum = sum_q;

	// controller picks exactly one of the two per sample
	a_push_clear_excl: assert property (
		@(posedge us_clk) disable iff (!resetn)
		!(lim.push && lim.clear)
	);

endmodule

`default_nettype wire

//--- source/limiter_ctrl.sv
// sequencer for the throttle conditioning path
// latches the sample, strobes history and curve, registers the result

`timescale 1ns/1ps
`default_nettype none

module limiter_ctrl import throttle_pkg::*; (
	input  wire      us_clk,
	input  wire      resetn,
	input  wire      start_signal,
	input  rec_val_t throttle_pwm_value_in,
	limiter_if.ctrl  lim,
	input  rec_val_t curve_value,
	output rec_val_t throttle_pwm_value_out,
	output logic     active_signal,
	output logic     complete_signal
);

	typedef enum logic [2:0] {
		ST_WAITING,
		ST_BUFFERING,
		ST_ADDING,
		ST_AVERAGING,
		ST_SCALING,
		ST_ASSIGNING,
		ST_COMPLETE
	} state_t;

	state_t   state;
	state_t   next_state;
	rec_val_t sample_q;

	// one step per cycle, start only looked at while waiting
	always_comb begin
		unique case (state)
			ST_WAITING:   next_state = start_signal ? ST_BUFFERING : ST_WAITING;
			ST_BUFFERING: next_state = ST_ADDING;
			ST_ADDING:    next_state = ST_AVERAGING;
			ST_AVERAGING: next_state = ST_SCALING;
			ST_SCALING:   next_state = ST_ASSIGNING;
			ST_ASSIGNING: next_state = ST_COMPLETE;
			ST_COMPLETE:  next_state = ST_WAITING;
			default:      next_state = ST_WAITING;
		endcase
	end

	always_ff @(posedge us_clk or negedge resetn) begin
		if (!resetn) begin
			state                  <= ST_WAITING;
			active_signal          <= 1'b0;
			complete_signal        <= 1'b0;
			throttle_pwm_value_out <= '0;
		end else begin
			state           <= next_state;
			active_signal   <= (state != ST_WAITING) && (state != ST_COMPLETE);
			complete_signal <= (state == ST_COMPLETE);
			if (state == ST_ASSIGNING)
				throttle_pwm_value_out <= curve_value;
		end
	end

	// input sample held for the buffering step
	always_ff @(posedge us_clk) begin
		if (state == ST_WAITING && start_signal)
			sample_q <= throttle_pwm_value_in;
	end

	// idle sample empties the history instead of entering it
	assign lim.sample       = sample_q;
	assign lim.push         = (state == ST_BUFFERING) && (sample_q >= IDLE_LIMIT);
	assign lim.clear        = (state == ST_BUFFERING) && (sample_q < IDLE_LIMIT);
	assign lim.add          = (state == ST_ADDING);
	assign lim.average_load = (state == ST_AVERAGING);
	assign lim.scale        = (state == ST_SCALING);

	a_complete_one_cycle: assert property (
		@(posedge us_clk) disable iff (!resetn)
		complete_signal |=> !complete_signal
	);

	a_active_complete_excl: assert property (
		@(posedge us_clk) disable iff (!resetn)
		!(active_signal && complete_signal)
	);

endmodule

`default_nettype wire

//--- source/limiter_if.sv
// controller strobes and history/curve datapath bundle
// modports for controller, history and curve

`timescale 1ns/1ps
`default_nettype none

interface limiter_if import throttle_pkg::*; ();

	// one-cycle strobes from the controller
	logic push;
	logic clear;
	logic add;
	logic average_load;
	logic scale;

	// latched sample and registered history sum
	rec_val_t sample;
	ops_t     sum;

	modport ctrl (
		output push, clear, add, average_load, scale, sample
	);

	modport hist (
		input  push, clear, add, sample,
		output sum
	);

	modport curve (
		input sum, average_load, scale
	);

endinterface

`default_nettype wire

//--- source/pwm_pkg.sv
// motor pulse frame counter type
// frame length and zero-throttle pulse width

`default_nettype none

package pwm_pkg;

	localparam int PWM_COUNT_W = 10;

	// tick position inside one motor frame
	typedef logic [PWM_COUNT_W-1:0] pwm_count_t;

	// one frame in us_clk ticks, wraps the counter
	localparam int PWM_FRAME_TICKS = 1024;

	// high width at throttle zero
	localparam pwm_count_t PWM_BASE_TICKS = 10'd256;

endpackage

`default_nettype wire

//--- source/throttle_pkg.sv
// throttle sample and arithmetic widths
// history depth and idle threshold
// breakpoints and offsets of the three-segment throttle curve

`default_nettype none

package throttle_pkg;

	// data widths
	localparam int REC_VAL_W = 8;
	localparam int OPS_W     = 16;

	// one receiver sample or conditioned throttle value
	typedef logic [REC_VAL_W-1:0] rec_val_t;

	// sum and curve working width
	typedef logic [OPS_W-1:0] ops_t;

	// moving average history
	localparam int HIST_DEPTH = 8;
	localparam int HIST_SHIFT = 3;

	// samples below this count as idle and power the motor off
	localparam rec_val_t IDLE_LIMIT = 8'd10;

	// curve segments, compared against the 8-bit average
	localparam ops_t CURVE_LOW_END     = 16'd42;
	localparam ops_t CURVE_HIGH_END    = 16'd209;
	localparam ops_t CURVE_MID_OFFSET  = 16'd61;
	localparam ops_t CURVE_HIGH_OFFSET = 16'd252;

	// output ceiling
	localparam ops_t REC_VAL_MAX = 16'd255;

endpackage

`default_nettype wire
